//--- src/ras_pkg.sv
package ras_pkg;

	// widths with a meaning
	typedef logic [31:0] addr_t;   // instruction address
	typedef logic [31:0] instr_t;  // raw instruction word
	typedef logic [4:0]  reg_idx_t;  // architectural register number
	typedef logic [6:0]  opcode_t;   // major opcode field

	// major opcodes of the two jumps
	localparam opcode_t OPC_JAL  = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;

	// ra and t0, the two link registers
	localparam reg_idx_t LINK_X1 = 5'd1;
	localparam reg_idx_t LINK_X5 = 5'd5;

	// stack entries unless the top level overrides it
	localparam int RAS_DEPTH_DEF = 4;

	// what a jump does to the return stack
	typedef enum logic [1:0] {
		NONE     = 2'd0,  // leave the stack alone
		PUSH     = 2'd1,  // call
		POP      = 2'd2,  // return
		POP_PUSH = 2'd3   // coroutine swap, top replaced
	} ras_op_t;

endpackage

//--- src/ras_op_if.sv
interface ras_op_if;

	logic            valid;       // instruction present this cycle
	ras_pkg::ras_op_t op;         // classified stack operation
	ras_pkg::addr_t  pc;          // pc of the instruction
	ras_pkg::addr_t  ret_addr;    // pc + 4, pushed on calls
	ras_pkg::addr_t  jal_target;  // pc + J-immediate
	logic            is_jal;      // direct jump, target known at decode

	// decode owns every signal
	modport decode (
		output valid, op, pc, ret_addr, jal_target, is_jal
	);

	// stack only needs to know what to do and what to push
	modport stack (
		input valid, op, ret_addr
	);

	// next-pc stage picks among jal target, stack top, fall-through
	modport next_pc (
		input valid, op, pc, ret_addr, jal_target, is_jal
	);

endinterface

//--- src/ras_decode.sv
module ras_decode (
	input  logic           instr_valid,
	input  ras_pkg::addr_t pc,
	input  ras_pkg::instr_t instr,
	ras_op_if.decode       op_if
);

	ras_pkg::opcode_t opcode;
	ras_pkg::reg_idx_t rd;
	ras_pkg::reg_idx_t rs1;
	ras_pkg::addr_t    j_imm;   // sign-extended J-type immediate
	logic              rd_link;  // rd is x1 or x5
	logic              rs1_link; // rs1 is x1 or x5
	logic              is_jal_op;
	logic              is_jalr_op;

	// instruction fields
	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];

	// imm[20|10:1|11|19:12] scattered over bits 31:12
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	assign rd_link  = (rd == ras_pkg::LINK_X1) || (rd == ras_pkg::LINK_X5);
	assign rs1_link = (rs1 == ras_pkg::LINK_X1) || (rs1 == ras_pkg::LINK_X5);

	assign is_jal_op  = (opcode == ras_pkg::OPC_JAL);
	assign is_jalr_op = (opcode == ras_pkg::OPC_JALR);

	// link-register hint rules of the base ISA
	always_comb begin
		op_if.op = ras_pkg::NONE;
		if (instr_valid) begin
			if (is_jal_op) begin
				if (rd_link)
					op_if.op = ras_pkg::PUSH;  // call
			end else if (is_jalr_op) begin
				case ({rd_link, rs1_link})
					2'b01: op_if.op = ras_pkg::POP;   // plain return
					2'b10: op_if.op = ras_pkg::PUSH;  // indirect call
					2'b11: begin
						// same link reg on both sides is a call
						if (rd == rs1)
							op_if.op = ras_pkg::PUSH;
						else
							op_if.op = ras_pkg::POP_PUSH;
					end
					default: op_if.op = ras_pkg::NONE;  // no link involved
				endcase
			end
		end
	end

	assign op_if.valid      = instr_valid;
	assign op_if.pc         = pc;
	assign op_if.ret_addr   = pc + 32'd4;       // fall-through / link value
	assign op_if.jal_target = pc + j_imm;
	assign op_if.is_jal     = instr_valid && is_jal_op;  // only meaningful when valid

endmodule

//--- src/ras_stack.sv
module ras_stack #(
	parameter int DEPTH = ras_pkg::RAS_DEPTH_DEF
) (
	input  logic           CLK,
	input  logic           nRST,
	input  logic           flush,
	ras_op_if.stack        op_if,
	output ras_pkg::addr_t top_addr,
	output logic           empty
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
	localparam int CW = $clog2(DEPTH + 1);                // count width up to DEPTH

	ras_pkg::addr_t  ras [DEPTH];  // return addresses
	logic [PW-1:0]   ptr;          // next slot to write
	logic [PW-1:0]   nxt_ptr;
	logic [PW-1:0]   ptr_inc;      // ptr + 1 mod DEPTH
	logic [PW-1:0]   top_idx;      // ptr - 1 mod DEPTH
	logic [CW-1:0]   count;        // saturating entry count
	logic [CW-1:0]   nxt_count;
	logic            full;
	logic            wr_en;
	logic [PW-1:0]   wr_idx;

	assign ptr_inc = (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	assign top_idx = (ptr == '0) ? PW'(DEPTH - 1) : ptr - 1'b1;

	assign empty    = (count == '0);
	assign full     = (count == CW'(DEPTH));
	assign top_addr = ras[top_idx];  // pre-update view for next-pc

	always_comb begin
		nxt_ptr   = ptr;
		nxt_count = count;
		wr_en     = 1'b0;
		wr_idx    = ptr;
		if (flush) begin
			// drop everything including this cycle's op
			nxt_ptr   = '0;
			nxt_count = '0;
		end else if (op_if.valid) begin
			case (op_if.op)
				ras_pkg::PUSH: begin
					wr_en     = 1'b1;
					nxt_ptr   = ptr_inc;
					nxt_count = full ? count : count + 1'b1;  // overflow drops oldest
				end
				ras_pkg::POP: begin
					if (!empty) begin
						nxt_ptr   = top_idx;
						nxt_count = count - 1'b1;
					end
				end
				ras_pkg::POP_PUSH: begin
					wr_en = 1'b1;
					if (!empty) begin
						wr_idx = top_idx;  // replace top in place
					end else begin
						nxt_ptr   = ptr_inc;  // empty stack acts as a push
						nxt_count = count + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ptr   <= '0;
			count <= '0;
		end else begin
			ptr   <= nxt_ptr;
			count <= nxt_count;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en)
			ras[wr_idx] <= op_if.ret_addr;
	end

	a_count_bound: assert property (@(posedge CLK) disable iff (!nRST)
		count <= CW'(DEPTH))
		else $error("occupancy %0d above depth %0d", count, DEPTH);

	// a real return retires exactly one entry
	a_pop_dec: assert property (@(posedge CLK) disable iff (!nRST)
		(op_if.valid && op_if.op == ras_pkg::POP && !empty && !flush)
		|=> (count == $past(count) - 1'b1))
		else $error("pop on non-empty stack did not lower the count");

endmodule

//--- src/ras_next_pc.sv
module ras_next_pc (
	input  logic           CLK,
	input  logic           nRST,
	ras_op_if.next_pc      op_if,
	input  ras_pkg::addr_t top_addr,
	input  logic           empty,
	output logic           pred_valid,
	output logic           pred_taken,
	output ras_pkg::addr_t pred_target
);

	ras_pkg::addr_t target;  // chosen this cycle
	logic           taken;
	logic           is_ret;  // op that reads the stack top

	assign is_ret = (op_if.op == ras_pkg::POP) || (op_if.op == ras_pkg::POP_PUSH);

	always_comb begin
		if (op_if.is_jal) begin
			target = op_if.jal_target;  // direct jump target known at decode
			taken  = 1'b1;
		end else if (is_ret && !empty) begin
			target = top_addr;  // predicted return
			taken  = 1'b1;
		end else begin
			target = op_if.ret_addr;  // fall through
			taken  = 1'b0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pred_valid <= 1'b0;
			pred_taken <= 1'b0;
		end else begin
			pred_valid <= op_if.valid;
			pred_taken <= taken;  // idle slots carry no jump and no pop
		end
	end

	// payload only meaningful with pred_valid
	always_ff @(posedge CLK) begin
		if (op_if.valid)
			pred_target <= target;
	end

	// decode must keep is_jal and the op quiet on idle slots
	a_taken_valid: assert property (@(posedge CLK) disable iff (!nRST)
		pred_taken |-> pred_valid)
		else $error("taken prediction without a valid slot");

endmodule

//--- src/ras_predictor.sv
module ras_predictor #(
	parameter int DEPTH = ras_pkg::RAS_DEPTH_DEF  // return stack entries, 2 or more
) (
	input  logic            CLK,
	input  logic            nRST,
	input  logic            instr_valid,  // fetch presents an instruction
	input  ras_pkg::addr_t  pc,
	input  ras_pkg::instr_t instr,
	input  logic            flush,        // empties the stack, wins over instr
	output logic            pred_valid,   // one cycle after instr_valid
	output logic            pred_taken,
	output ras_pkg::addr_t  pred_target
);

	ras_pkg::addr_t top_addr;  // stack top before this cycle's update
	logic           empty;

	// classified op shared by all three stages
	ras_op_if op_if ();

	// comb classification
	ras_decode u_decode (
		.instr_valid (instr_valid),
		.pc          (pc),
		.instr       (instr),
		.op_if       (op_if.decode)
	);

	ras_stack #(
		.DEPTH (DEPTH)
	) u_stack (
		.CLK      (CLK),
		.nRST     (nRST),
		.flush    (flush),
		.op_if    (op_if.stack),
		.top_addr (top_addr),
		.empty    (empty)
	);

	// registered prediction out
	ras_next_pc u_next_pc (
		.CLK         (CLK),
		.nRST        (nRST),
		.op_if       (op_if.next_pc),
		.top_addr    (top_addr),
		.empty       (empty),
		.pred_valid  (pred_valid),
		.pred_taken  (pred_taken),
		.pred_target (pred_target)
	);

endmodule

//--- bench/ras_predictor_tb.sv
module ras_predictor_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 4;
	localparam int DRAIN_LIMIT = 16;  // cycles before a drain gives up

	logic            CLK;
	logic            nRST;
	logic            instr_valid;
	ras_pkg::addr_t  pc;
	ras_pkg::instr_t instr;
	logic            flush;
	logic            pred_valid;
	logic            pred_taken;
	ras_pkg::addr_t  pred_target;

	ras_pkg::addr_t  shadow [$];   // model stack with newest at the back
	logic            cur_taken;    // expectation for the instruction on the inputs
	ras_pkg::addr_t  cur_target;
	logic            exp_valid;    // one-deep expectation slot aligned with outputs
	logic            exp_taken;
	ras_pkg::addr_t  exp_target;
	logic [15:0]     lfsr = 16'd52;
	string           test_name = "none";
	int              errors = 0;
	int              timeouts = 0;
	int              tests_ok = 0;
	int              tests_bad = 0;
	int              fails_before;

	ras_predictor #(
		.DEPTH (DEPTH)
	) u_dut (
		.CLK         (CLK),
		.nRST        (nRST),
		.instr_valid (instr_valid),
		.pc          (pc),
		.instr       (instr),
		.flush       (flush),
		.pred_valid  (pred_valid),
		.pred_taken  (pred_taken),
		.pred_target (pred_target)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;  // 4 ns period
	end

	// expectation moves one stage like the registered outputs
	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			exp_valid <= 1'b0;
			exp_taken <= 1'b0;
		end else begin
			exp_valid  <= instr_valid;
			exp_taken  <= cur_taken;
			exp_target <= cur_target;
		end
	end

	task automatic log_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("ERROR %s: %s expected %h, actual %h", test_name, what, exp, act);
	endtask

	a_valid: assert property (@(posedge CLK) disable iff (!nRST) pred_valid == exp_valid)
		else log_mismatch("pred_valid", $sampled(exp_valid), $sampled(pred_valid));
	a_taken: assert property (@(posedge CLK) disable iff (!nRST)
		pred_taken == (exp_valid && exp_taken))
		else log_mismatch("pred_taken", $sampled(exp_valid && exp_taken), $sampled(pred_taken));
	a_target: assert property (@(posedge CLK) disable iff (!nRST)
		exp_valid |-> pred_target == exp_target)
		else log_mismatch("pred_target", $sampled(exp_target), $sampled(pred_target));

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], lfsr_step()};  // one step per bit
		return v;
	endfunction

	// J-type layout with off as the byte offset
	function automatic ras_pkg::instr_t jal_word(input ras_pkg::reg_idx_t rd,
			input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, ras_pkg::OPC_JAL};
	endfunction

	function automatic ras_pkg::instr_t jalr_word(input ras_pkg::reg_idx_t rd,
			input ras_pkg::reg_idx_t rs1);
		return {12'h000, rs1, 3'b000, rd, ras_pkg::OPC_JALR};
	endfunction

	function automatic ras_pkg::instr_t addi_word(input ras_pkg::reg_idx_t rd,
			input ras_pkg::reg_idx_t rs1);
		return {12'h001, rs1, 3'b000, rd, 7'b0010011};  // not a jump
	endfunction

	// reference model driving cur_* and the shadow stack
	task automatic predict(input ras_pkg::addr_t p, input ras_pkg::instr_t i, input logic fl,
			input logic [20:0] off);
		ras_pkg::reg_idx_t rd;
		ras_pkg::reg_idx_t rs1;
		logic              rd_is_link;
		logic              rs1_is_link;
		logic              push;
		logic              pop;
		logic              tk;
		ras_pkg::addr_t    tgt;
		rd          = i[11:7];
		rs1         = i[19:15];
		rd_is_link  = (rd == 5'd1) || (rd == 5'd5);
		rs1_is_link = (rs1 == 5'd1) || (rs1 == 5'd5);
		push = 1'b0;
		pop  = 1'b0;
		tk   = 1'b0;
		tgt  = p + 32'd4;  // fall through
		if (i[6:0] == ras_pkg::OPC_JAL) begin
			tk   = 1'b1;
			tgt  = p + {{11{off[20]}}, off};  // offset the call was built with
			push = rd_is_link;
		end else if (i[6:0] == ras_pkg::OPC_JALR) begin
			pop  = rs1_is_link && !(rd_is_link && rd == rs1);  // same reg is a call
			push = rd_is_link;
			if (pop && shadow.size() > 0) begin
				tk  = 1'b1;
				tgt = shadow[$];
			end
		end
		if (fl)
			shadow.delete();  // flush beats the op
		else begin
			if (pop && shadow.size() > 0)
				void'(shadow.pop_back());
			if (push) begin
				shadow.push_back(p + 32'd4);
				if (shadow.size() > DEPTH)
					void'(shadow.pop_front());  // oldest lost
			end
		end
		cur_taken  <= tk;
		cur_target <= tgt;
	endtask

	task automatic issue(input ras_pkg::addr_t p, input ras_pkg::instr_t i,
			input logic fl = 1'b0, input logic [20:0] off = '0);
		@(posedge CLK);
		instr_valid <= 1'b1;
		pc          <= p;
		instr       <= i;
		flush       <= fl;
		predict(p, i, fl, off);
	endtask

	// JAL whose expected target comes from the chosen offset
	task automatic jump_and_link(input ras_pkg::addr_t p, input ras_pkg::reg_idx_t rd,
			input logic [20:0] off, input logic fl = 1'b0);
		issue(p, jal_word(rd, off), fl, off);
	endtask

	// go idle and wait for the last prediction to leave
	task automatic drain();
		int waited;
		waited = 0;
		@(posedge CLK);
		instr_valid <= 1'b0;
		flush       <= 1'b0;
		do begin
			@(posedge CLK);
			waited++;
		end while ((exp_valid || pred_valid) && waited < DRAIN_LIMIT);
		if (exp_valid || pred_valid) begin
			timeouts++;
			$display("timeout in test %s: the prediction outputs never went idle", test_name);
		end
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		fails_before = errors + timeouts;
	endtask

	task automatic end_test();
		if (errors + timeouts == fails_before) begin
			tests_ok++;
			$display("test %-10s pass", test_name);
		end else begin
			tests_bad++;
			$display("test %-10s fail, %0d problems", test_name, errors + timeouts - fails_before);
		end
	endtask

	function automatic ras_pkg::reg_idx_t pick_reg();
		case (rand_bits(2))
			0:       return 5'd1;
			1:       return 5'd5;
			2:       return 5'd0;
			default: return 5'd10 + 5'(rand_bits(3));  // some non-link reg
		endcase
	endfunction

	task automatic run_random(input int n);
		logic [31:0]       r;
		ras_pkg::addr_t    p;
		ras_pkg::instr_t   i;
		ras_pkg::reg_idx_t rd;
		ras_pkg::reg_idx_t rs1;
		logic [20:0]       off;
		logic              fl;
		for (int k = 0; k < n; k++) begin
			r   = rand_bits(2);  // instruction kind
			rd  = pick_reg();
			rs1 = pick_reg();
			p   = {14'h0, 16'(rand_bits(16)), 2'b00};
			off = '0;
			if (r == 0) begin
				off = {20'(rand_bits(20)), 1'b0};
				i   = jal_word(rd, off);
			end else if (r == 3)
				i = addi_word(rd, rs1);
			else
				i = jalr_word(rd, rs1);  // twice as likely to keep the stack busy
			fl = (rand_bits(4) == 0);
			issue(p, i, fl, off);
		end
		drain();
	endtask

	initial begin
		nRST        = 1'b0;
		instr_valid = 1'b0;
		pc          = '0;
		instr       = '0;
		flush       = 1'b0;
		cur_taken   = 1'b0;
		cur_target  = '0;
		repeat (2) @(posedge CLK);
		nRST <= 1'b1;

		start_test("reset");  // outputs stay low while idle
		drain();
		drain();
		end_test();

		start_test("jal");
		jump_and_link(32'h100, 5'd1, 21'h40);
		issue(32'h200, jalr_word(5'd0, 5'd1));  // returns to 0x104
		drain();
		end_test();

		start_test("nested");
		jump_and_link(32'h1000, 5'd1, 21'h100);
		jump_and_link(32'h1100, 5'd5, 21'h100);
		jump_and_link(32'h1200, 5'd1, 21'h1fff00);  // backward call
		for (int k = 0; k < 4; k++)
			issue(32'h3000 + 32'(k * 8), jalr_word(5'd0, 5'd1));  // last one on empty
		drain();
		end_test();

		start_test("jalr_rules");
		jump_and_link(32'h400, 5'd0, 21'h20);     // plain jump without push
		issue(32'h404, jalr_word(5'd1, 5'd10));   // indirect call
		issue(32'h408, jalr_word(5'd1, 5'd1));    // same link on both sides pushes only
		issue(32'h40c, jalr_word(5'd5, 5'd1));    // swap replaces the top
		issue(32'h410, jalr_word(5'd0, 5'd10));   // no link
		issue(32'h414, addi_word(5'd1, 5'd5));    // not a jump
		for (int k = 0; k < 3; k++)
			issue(32'h480, jalr_word(5'd0, 5'd5));
		issue(32'h500, jalr_word(5'd1, 5'd5));    // swap on empty acts as push
		issue(32'h600, jalr_word(5'd0, 5'd1));
		drain();
		end_test();

		start_test("overflow");
		for (int k = 0; k < 5; k++)
			jump_and_link(32'h700 + 32'(k * 16), 5'd1, 21'h8);
		for (int k = 0; k < 5; k++)
			issue(32'h900, jalr_word(5'd0, 5'd1));  // newest four then empty
		jump_and_link(32'ha00, 5'd1, 21'h10);
		jump_and_link(32'ha10, 5'd1, 21'h10, 1'b1);  // push dropped by flush
		jump_and_link(32'ha20, 5'd1, 21'h10);
		issue(32'ha30, jalr_word(5'd0, 5'd1), 1'b1);   // predicts from old top
		issue(32'ha40, jalr_word(5'd0, 5'd1));         // stack gone
		drain();
		end_test();

		start_test("random");
		run_random(200);
		end_test();

		$display("summary: %0d tests passed, %0d failed, %0d mismatches, %0d timeouts",
			tests_ok, tests_bad, errors, timeouts);
		if (tests_bad == 0 && errors == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- verilog.f
src/ras_pkg.sv
src/ras_op_if.sv
src/ras_decode.sv
src/ras_stack.sv
src/ras_next_pc.sv
src/ras_predictor.sv
bench/ras_predictor_tb.sv
